// File: tcm_pkg.sv
// shared widths, response codes and default memory map of the TCM subsystem
package tcm_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    // response codes as seen by both master ports
    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

    // default map, each bank holds 2**index_w words
    localparam logic [addr_w-1:0] itcm_base_default = 32'h0000_0000;
    localparam logic [addr_w-1:0] dtcm_base_default = 32'h0001_0000;
    localparam int tcm_index_w_default = 10;

endpackage

// File: tcm_bank.sv
// TCM memory bank with single-beat read and write channels and byte strobes
`timescale 1ns/1ps

module tcm_bank #(
    parameter int INDEX_W = tcm_pkg::tcm_index_w_default
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    input  logic [INDEX_W-1:0]         ar_index,
    output logic                       r_valid,
    input  logic                       r_ready,
    output logic [tcm_pkg::data_w-1:0] r_data,
    input  logic                       aw_valid,
    input  logic                       w_valid,
    output logic                       aw_ready,
    input  logic [INDEX_W-1:0]         aw_index,
    input  logic [tcm_pkg::data_w-1:0] w_data,
    input  logic [tcm_pkg::strb_w-1:0] w_strb,
    output logic                       b_valid,
    input  logic                       b_ready
);

    logic [tcm_pkg::data_w-1:0] mem [0:(1<<INDEX_W)-1];
    logic                       rd_fire;
    logic                       wr_fire;

    // slot is free when empty or drained in this cycle
    assign ar_ready = !r_valid || r_ready;
    assign aw_ready = !b_valid || b_ready;
    assign rd_fire  = ar_valid && ar_ready;
    // write needs address and data together
    assign wr_fire  = aw_valid && w_valid && aw_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            r_valid <= rd_fire || (r_valid && !r_ready);
            b_valid <= wr_fire || (b_valid && !b_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data <= mem[ar_index];
        end
        if (wr_fire) begin
            // merge strobed bytes into the stored word
            for (int i = 0; i < tcm_pkg::strb_w; i++) begin
                if (w_strb[i]) begin
                    mem[aw_index][8*i +: 8] <= w_data[8*i +: 8];
                end
            end
        end
    end

    // read data held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> $stable(r_data));

endmodule

// File: itcm_read_arbiter.sv
// ITCM read arbiter: shares the bank read channel between fetch and data ports
`timescale 1ns/1ps

module itcm_read_arbiter #(
    parameter logic [tcm_pkg::addr_w-1:0] ITCM_BASE    = tcm_pkg::itcm_base_default,
    parameter int                         ITCM_INDEX_W = tcm_pkg::tcm_index_w_default
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fetch_ar_valid,
    output logic                       fetch_ar_ready,
    input  logic [tcm_pkg::addr_w-1:0] fetch_ar_addr,
    output logic                       fetch_r_valid,
    input  logic                       fetch_r_ready,
    output logic [tcm_pkg::data_w-1:0] fetch_r_data,
    output logic [tcm_pkg::resp_w-1:0] fetch_r_resp,
    input  logic                       itcm_ar_valid,
    output logic                       itcm_ar_ready,
    input  logic [tcm_pkg::addr_w-1:0] itcm_ar_addr,
    output logic                       itcm_r_valid,
    input  logic                       itcm_r_ready,
    output logic [tcm_pkg::data_w-1:0] itcm_r_data,
    output logic                       bank_ar_valid,
    input  logic                       bank_ar_ready,
    output logic [ITCM_INDEX_W-1:0]    bank_ar_index,
    input  logic                       bank_r_valid,
    output logic                       bank_r_ready,
    input  logic [tcm_pkg::data_w-1:0] bank_r_data
);

    localparam int aw  = tcm_pkg::addr_w;
    localparam int lsb = ITCM_INDEX_W + 2;

    logic fetch_hit;
    logic fetch_free;
    logic fetch_grant;
    logic owner_fetch;
    logic ferr_valid;

    assign fetch_hit   = fetch_ar_addr[aw-1:lsb] == ITCM_BASE[aw-1:lsb];
    assign fetch_free  = !fetch_r_valid || fetch_r_ready;
    // data port wins the bank, fetch waits
    assign fetch_grant = fetch_ar_valid && fetch_hit && fetch_free && !itcm_ar_valid;

    // out-of-window fetch only needs a free response slot
    assign fetch_ar_ready = fetch_free && (fetch_hit ? !itcm_ar_valid && bank_ar_ready : 1'b1);
    assign itcm_ar_ready  = bank_ar_ready;

    assign bank_ar_valid = itcm_ar_valid || fetch_grant;
    assign bank_ar_index = itcm_ar_valid ? itcm_ar_addr[lsb-1:2] : fetch_ar_addr[lsb-1:2];

    // steer the bank response by owner of the last accepted read
    assign bank_r_ready  = owner_fetch ? fetch_r_ready : itcm_r_ready;
    assign itcm_r_valid  = bank_r_valid && !owner_fetch;
    assign itcm_r_data   = bank_r_data;
    assign fetch_r_valid = ferr_valid || (bank_r_valid && owner_fetch);
    assign fetch_r_data  = ferr_valid ? '0 : bank_r_data;
    assign fetch_r_resp  = ferr_valid ? tcm_pkg::resp_slverr : tcm_pkg::resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_fetch <= 1'b0;
            ferr_valid  <= 1'b0;
        end else begin
            if (bank_ar_valid && bank_ar_ready) begin
                owner_fetch <= !itcm_ar_valid;
            end
            ferr_valid <= (fetch_ar_valid && fetch_ar_ready && !fetch_hit)
                        || (ferr_valid && !fetch_r_ready);
        end
    end

    // a data grant takes the bank alone, so its response goes to the router
    assert property (@(posedge clk) disable iff (!rst_n)
        itcm_ar_valid && itcm_ar_ready |=> itcm_r_valid);

endmodule

// File: data_port_router.sv
// data port router: decodes reads and writes to ITCM, DTCM or error and routes responses
`timescale 1ns/1ps

module data_port_router #(
    parameter logic [tcm_pkg::addr_w-1:0] ITCM_BASE    = tcm_pkg::itcm_base_default,
    parameter logic [tcm_pkg::addr_w-1:0] DTCM_BASE    = tcm_pkg::dtcm_base_default,
    parameter int                         ITCM_INDEX_W = tcm_pkg::tcm_index_w_default,
    parameter int                         DTCM_INDEX_W = tcm_pkg::tcm_index_w_default
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       data_ar_valid,
    output logic                       data_ar_ready,
    input  logic [tcm_pkg::addr_w-1:0] data_ar_addr,
    output logic                       data_r_valid,
    input  logic                       data_r_ready,
    output logic [tcm_pkg::data_w-1:0] data_r_data,
    output logic [tcm_pkg::resp_w-1:0] data_r_resp,
    input  logic                       data_aw_valid,
    input  logic [tcm_pkg::addr_w-1:0] data_aw_addr,
    input  logic                       data_w_valid,
    input  logic [tcm_pkg::data_w-1:0] data_w_data,
    input  logic [tcm_pkg::strb_w-1:0] data_w_strb,
    output logic                       data_aw_ready,
    output logic                       data_b_valid,
    input  logic                       data_b_ready,
    output logic [tcm_pkg::resp_w-1:0] data_b_resp,
    output logic                       itcm_ar_valid,
    input  logic                       itcm_ar_ready,
    output logic [tcm_pkg::addr_w-1:0] itcm_ar_addr,
    input  logic                       itcm_r_valid,
    output logic                       itcm_r_ready,
    input  logic [tcm_pkg::data_w-1:0] itcm_r_data,
    output logic                       itcm_aw_valid,
    output logic                       itcm_w_valid,
    input  logic                       itcm_aw_ready,
    output logic [ITCM_INDEX_W-1:0]    itcm_aw_index,
    output logic [tcm_pkg::data_w-1:0] itcm_w_data,
    output logic [tcm_pkg::strb_w-1:0] itcm_w_strb,
    input  logic                       itcm_b_valid,
    output logic                       itcm_b_ready,
    output logic                       dtcm_ar_valid,
    input  logic                       dtcm_ar_ready,
    output logic [DTCM_INDEX_W-1:0]    dtcm_ar_index,
    input  logic                       dtcm_r_valid,
    output logic                       dtcm_r_ready,
    input  logic [tcm_pkg::data_w-1:0] dtcm_r_data,
    output logic                       dtcm_aw_valid,
    output logic                       dtcm_w_valid,
    input  logic                       dtcm_aw_ready,
    output logic [DTCM_INDEX_W-1:0]    dtcm_aw_index,
    output logic [tcm_pkg::data_w-1:0] dtcm_w_data,
    output logic [tcm_pkg::strb_w-1:0] dtcm_w_strb,
    input  logic                       dtcm_b_valid,
    output logic                       dtcm_b_ready
);

    localparam int         aw       = tcm_pkg::addr_w;
    localparam int         ilsb     = ITCM_INDEX_W + 2;
    localparam int         dlsb     = DTCM_INDEX_W + 2;
    localparam logic [1:0] tgt_itcm = 2'd0;
    localparam logic [1:0] tgt_dtcm = 2'd1;
    localparam logic [1:0] tgt_err  = 2'd2;

    logic       rd_pend;
    logic       wr_pend;
    logic [1:0] rd_tgt;
    logic [1:0] wr_tgt;
    logic [1:0] rd_new;
    logic [1:0] wr_new;
    logic       rd_free;
    logic       wr_free;

    // window match on the upper address bits
    function automatic logic [1:0] decode(input logic [aw-1:0] addr);
        if (addr[aw-1:ilsb] == ITCM_BASE[aw-1:ilsb]) begin
            return tgt_itcm;
        end else if (addr[aw-1:dlsb] == DTCM_BASE[aw-1:dlsb]) begin
            return tgt_dtcm;
        end
        return tgt_err;
    endfunction

    assign rd_new = decode(data_ar_addr);
    assign wr_new = decode(data_aw_addr);

    // one read and one write in flight, so no reordering across targets
    assign rd_free = !rd_pend || (data_r_valid && data_r_ready);
    assign wr_free = !wr_pend || (data_b_valid && data_b_ready);

    assign itcm_ar_valid = data_ar_valid && rd_free && rd_new == tgt_itcm;
    assign itcm_ar_addr  = data_ar_addr;
    assign dtcm_ar_valid = data_ar_valid && rd_free && rd_new == tgt_dtcm;
    assign dtcm_ar_index = data_ar_addr[dlsb-1:2];
    assign data_ar_ready = rd_free && (rd_new == tgt_itcm ? itcm_ar_ready :
                                       rd_new == tgt_dtcm ? dtcm_ar_ready : 1'b1);

    // error response is the pending flag itself
    assign data_r_valid = rd_pend && (rd_tgt == tgt_itcm ? itcm_r_valid :
                                      rd_tgt == tgt_dtcm ? dtcm_r_valid : 1'b1);
    assign data_r_data  = rd_tgt == tgt_itcm ? itcm_r_data :
                          rd_tgt == tgt_dtcm ? dtcm_r_data : '0;
    assign data_r_resp  = rd_tgt == tgt_err ? tcm_pkg::resp_slverr : tcm_pkg::resp_okay;
    assign itcm_r_ready = rd_pend && rd_tgt == tgt_itcm && data_r_ready;
    assign dtcm_r_ready = rd_pend && rd_tgt == tgt_dtcm && data_r_ready;

    assign itcm_aw_valid = data_aw_valid && wr_free && wr_new == tgt_itcm;
    assign itcm_w_valid  = data_w_valid && wr_free && wr_new == tgt_itcm;
    assign itcm_aw_index = data_aw_addr[ilsb-1:2];
    assign itcm_w_data   = data_w_data;
    assign itcm_w_strb   = data_w_strb;
    assign dtcm_aw_valid = data_aw_valid && wr_free && wr_new == tgt_dtcm;
    assign dtcm_w_valid  = data_w_valid && wr_free && wr_new == tgt_dtcm;
    assign dtcm_aw_index = data_aw_addr[dlsb-1:2];
    assign dtcm_w_data   = data_w_data;
    assign dtcm_w_strb   = data_w_strb;
    assign data_aw_ready = wr_free && (wr_new == tgt_itcm ? itcm_aw_ready :
                                       wr_new == tgt_dtcm ? dtcm_aw_ready : 1'b1);

    assign data_b_valid = wr_pend && (wr_tgt == tgt_itcm ? itcm_b_valid :
                                      wr_tgt == tgt_dtcm ? dtcm_b_valid : 1'b1);
    assign data_b_resp  = wr_tgt == tgt_err ? tcm_pkg::resp_slverr : tcm_pkg::resp_okay;
    assign itcm_b_ready = wr_pend && wr_tgt == tgt_itcm && data_b_ready;
    assign dtcm_b_ready = wr_pend && wr_tgt == tgt_dtcm && data_b_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rd_tgt  <= tgt_err;
            wr_pend <= 1'b0;
            wr_tgt  <= tgt_err;
        end else begin
            if (data_ar_valid && data_ar_ready) begin
                rd_pend <= 1'b1;
                rd_tgt  <= rd_new;
            end else if (data_r_valid && data_r_ready) begin
                rd_pend <= 1'b0;
            end
            if (data_aw_valid && data_w_valid && data_aw_ready) begin
                wr_pend <= 1'b1;
                wr_tgt  <= wr_new;
            end else if (data_b_valid && data_b_ready) begin
                wr_pend <= 1'b0;
            end
        end
    end

    // banks only answer reads this port has issued
    assert property (@(posedge clk) disable iff (!rst_n)
        (itcm_r_valid || dtcm_r_valid) |-> rd_pend);

endmodule

// File: tcm_subsystem.sv
// TCM subsystem top: data port router, ITCM read arbiter and the two memory banks
`timescale 1ns/1ps

module tcm_subsystem #(
    parameter logic [tcm_pkg::addr_w-1:0] ITCM_BASE    = tcm_pkg::itcm_base_default,
    parameter logic [tcm_pkg::addr_w-1:0] DTCM_BASE    = tcm_pkg::dtcm_base_default,
    parameter int                         ITCM_INDEX_W = tcm_pkg::tcm_index_w_default,
    parameter int                         DTCM_INDEX_W = tcm_pkg::tcm_index_w_default
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fetch_ar_valid,
    output logic                       fetch_ar_ready,
    input  logic [tcm_pkg::addr_w-1:0] fetch_ar_addr,
    output logic                       fetch_r_valid,
    input  logic                       fetch_r_ready,
    output logic [tcm_pkg::data_w-1:0] fetch_r_data,
    output logic [tcm_pkg::resp_w-1:0] fetch_r_resp,
    input  logic                       data_ar_valid,
    output logic                       data_ar_ready,
    input  logic [tcm_pkg::addr_w-1:0] data_ar_addr,
    output logic                       data_r_valid,
    input  logic                       data_r_ready,
    output logic [tcm_pkg::data_w-1:0] data_r_data,
    output logic [tcm_pkg::resp_w-1:0] data_r_resp,
    input  logic                       data_aw_valid,
    output logic                       data_aw_ready,
    input  logic [tcm_pkg::addr_w-1:0] data_aw_addr,
    input  logic                       data_w_valid,
    output logic                       data_w_ready,
    input  logic [tcm_pkg::data_w-1:0] data_w_data,
    input  logic [tcm_pkg::strb_w-1:0] data_w_strb,
    output logic                       data_b_valid,
    input  logic                       data_b_ready,
    output logic [tcm_pkg::resp_w-1:0] data_b_resp
);

    // data-side ITCM read request and routed response
    logic                       itcm_ar_valid, itcm_ar_ready, itcm_r_valid, itcm_r_ready;
    logic [tcm_pkg::addr_w-1:0] itcm_ar_addr;
    logic [tcm_pkg::data_w-1:0] itcm_r_data;
    // ITCM bank read side behind the arbiter
    logic                       bank_ar_valid, bank_ar_ready, bank_r_valid, bank_r_ready;
    logic [ITCM_INDEX_W-1:0]    bank_ar_index;
    logic [tcm_pkg::data_w-1:0] bank_r_data;
    // ITCM bank write side
    logic                       itcm_aw_valid, itcm_w_valid, itcm_aw_ready;
    logic                       itcm_b_valid, itcm_b_ready;
    logic [ITCM_INDEX_W-1:0]    itcm_aw_index;
    logic [tcm_pkg::data_w-1:0] itcm_w_data;
    logic [tcm_pkg::strb_w-1:0] itcm_w_strb;
    // DTCM bank
    logic                       dtcm_ar_valid, dtcm_ar_ready, dtcm_r_valid, dtcm_r_ready;
    logic                       dtcm_aw_valid, dtcm_w_valid, dtcm_aw_ready;
    logic                       dtcm_b_valid, dtcm_b_ready;
    logic [DTCM_INDEX_W-1:0]    dtcm_ar_index, dtcm_aw_index;
    logic [tcm_pkg::data_w-1:0] dtcm_r_data, dtcm_w_data;
    logic [tcm_pkg::strb_w-1:0] dtcm_w_strb;

    // address and data of a write are accepted together
    assign data_w_ready = data_aw_ready;

    data_port_router #(
        .ITCM_BASE    (ITCM_BASE),
        .DTCM_BASE    (DTCM_BASE),
        .ITCM_INDEX_W (ITCM_INDEX_W),
        .DTCM_INDEX_W (DTCM_INDEX_W)
    ) data_port_router_inst (.*);

    itcm_read_arbiter #(
        .ITCM_BASE    (ITCM_BASE),
        .ITCM_INDEX_W (ITCM_INDEX_W)
    ) itcm_read_arbiter_inst (.*);

    tcm_bank #(.INDEX_W(ITCM_INDEX_W)) itcm_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (bank_ar_valid),
        .ar_ready (bank_ar_ready),
        .ar_index (bank_ar_index),
        .r_valid  (bank_r_valid),
        .r_ready  (bank_r_ready),
        .r_data   (bank_r_data),
        .aw_valid (itcm_aw_valid),
        .w_valid  (itcm_w_valid),
        .aw_ready (itcm_aw_ready),
        .aw_index (itcm_aw_index),
        .w_data   (itcm_w_data),
        .w_strb   (itcm_w_strb),
        .b_valid  (itcm_b_valid),
        .b_ready  (itcm_b_ready)
    );

    tcm_bank #(.INDEX_W(DTCM_INDEX_W)) dtcm_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (dtcm_ar_valid),
        .ar_ready (dtcm_ar_ready),
        .ar_index (dtcm_ar_index),
        .r_valid  (dtcm_r_valid),
        .r_ready  (dtcm_r_ready),
        .r_data   (dtcm_r_data),
        .aw_valid (dtcm_aw_valid),
        .w_valid  (dtcm_w_valid),
        .aw_ready (dtcm_aw_ready),
        .aw_index (dtcm_aw_index),
        .w_data   (dtcm_w_data),
        .w_strb   (dtcm_w_strb),
        .b_valid  (dtcm_b_valid),
        .b_ready  (dtcm_b_ready)
    );

endmodule

// File: tb_tcm_subsystem.sv
// testbench for the TCM subsystem with memory model, response assertions and watchdog
`timescale 1ns/1ps

module tb_tcm_subsystem;

    localparam int aw          = tcm_pkg::addr_w;
    localparam int dw          = tcm_pkg::data_w;
    localparam int rw          = tcm_pkg::resp_w;
    localparam int sw          = tcm_pkg::strb_w;
    localparam int lsb         = tcm_pkg::tcm_index_w_default + 2;
    localparam int clk_period  = 40;
    localparam int n_transfers = 15;
    localparam logic [aw-1:0] itcm_base = tcm_pkg::itcm_base_default;
    localparam logic [aw-1:0] dtcm_base = tcm_pkg::dtcm_base_default;

    logic          clk, rst_n;
    logic          fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
    logic          data_ar_valid, data_ar_ready, data_r_valid, data_r_ready;
    logic          data_aw_valid, data_aw_ready, data_w_valid, data_w_ready;
    logic          data_b_valid, data_b_ready;
    logic [aw-1:0] fetch_ar_addr, data_ar_addr, data_aw_addr;
    logic [dw-1:0] fetch_r_data, data_r_data, data_w_data;
    logic [rw-1:0] fetch_r_resp, data_r_resp, data_b_resp;
    logic [sw-1:0] data_w_strb;

    // word models of both banks
    logic [dw-1:0] itcm_model [0:(1<<tcm_pkg::tcm_index_w_default)-1];
    logic [dw-1:0] dtcm_model [0:(1<<tcm_pkg::tcm_index_w_default)-1];
    logic [dw-1:0] exp_fetch_data, exp_data_data;
    logic [rw-1:0] exp_fetch_resp, exp_data_resp, exp_b_resp;
    int            seed = 32'h660d;
    int            errors, checks, tests, failed_tests, errors_at_start;

    tcm_subsystem tcm_subsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic bit in_itcm(input logic [aw-1:0] addr);
        return addr[aw-1:lsb] == itcm_base[aw-1:lsb];
    endfunction

    function automatic bit in_dtcm(input logic [aw-1:0] addr);
        return addr[aw-1:lsb] == dtcm_base[aw-1:lsb];
    endfunction

    // out-of-window reads carry zero data
    function automatic logic [dw-1:0] model_word(input logic [aw-1:0] addr);
        if (in_itcm(addr)) begin
            return itcm_model[addr[lsb-1:2]];
        end else if (in_dtcm(addr)) begin
            return dtcm_model[addr[lsb-1:2]];
        end
        return '0;
    endfunction

    task automatic model_write(input logic [aw-1:0] addr, input logic [dw-1:0] data,
                               input logic [sw-1:0] strb);
        for (int i = 0; i < sw; i++) begin
            if (strb[i] && in_itcm(addr)) begin
                itcm_model[addr[lsb-1:2]][8*i +: 8] = data[8*i +: 8];
            end else if (strb[i] && in_dtcm(addr)) begin
                dtcm_model[addr[lsb-1:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [dw-1:0] got,
                                   input logic [dw-1:0] exp);
        errors++;
        $display("Fail %s: got %h expected %h", name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic write_word(input logic [aw-1:0] addr, input logic [dw-1:0] data,
                              input logic [sw-1:0] strb);
        @(negedge clk);
        exp_b_resp = (in_itcm(addr) || in_dtcm(addr)) ? tcm_pkg::resp_okay
                                                       : tcm_pkg::resp_slverr;
        data_aw_valid = 1'b1;
        data_w_valid  = 1'b1;
        data_aw_addr  = addr;
        data_w_data   = data;
        data_w_strb   = strb;
        do @(posedge clk); while (!(data_aw_ready && data_w_ready));
        model_write(addr, data, strb);
        @(negedge clk);
        data_aw_valid = 1'b0;
        data_w_valid  = 1'b0;
        while (!data_b_valid) @(negedge clk);
        @(negedge clk);
    endtask

    // hold keeps r_ready low for that many cycles after r_valid
    task automatic read_data(input logic [aw-1:0] addr, input int hold);
        @(negedge clk);
        exp_data_data = model_word(addr);
        exp_data_resp = (in_itcm(addr) || in_dtcm(addr)) ? tcm_pkg::resp_okay
                                                          : tcm_pkg::resp_slverr;
        data_ar_valid = 1'b1;
        data_ar_addr  = addr;
        data_r_ready  = (hold == 0);
        do @(posedge clk); while (!data_ar_ready);
        @(negedge clk);
        data_ar_valid = 1'b0;
        while (!data_r_valid) @(negedge clk);
        repeat (hold) @(negedge clk);
        data_r_ready = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_fetch(input logic [aw-1:0] addr, input int hold);
        @(negedge clk);
        exp_fetch_data = in_itcm(addr) ? model_word(addr) : '0;
        exp_fetch_resp = in_itcm(addr) ? tcm_pkg::resp_okay : tcm_pkg::resp_slverr;
        fetch_ar_valid = 1'b1;
        fetch_ar_addr  = addr;
        fetch_r_ready  = (hold == 0);
        do @(posedge clk); while (!fetch_ar_ready);
        @(negedge clk);
        fetch_ar_valid = 1'b0;
        while (!fetch_r_valid) @(negedge clk);
        repeat (hold) @(negedge clk);
        fetch_r_ready = 1'b1;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // response checks against the model
    assert property (@(posedge clk) disable iff (!rst_n)
        data_r_valid && data_r_ready |-> data_r_data == exp_data_data)
        else report_mismatch("data_r_data", $sampled(data_r_data), exp_data_data);
    assert property (@(posedge clk) disable iff (!rst_n)
        data_r_valid && data_r_ready |-> data_r_resp == exp_data_resp)
        else report_mismatch("data_r_resp", dw'($sampled(data_r_resp)), dw'(exp_data_resp));
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid && fetch_r_ready |-> fetch_r_data == exp_fetch_data)
        else report_mismatch("fetch_r_data", $sampled(fetch_r_data), exp_fetch_data);
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid && fetch_r_ready |-> fetch_r_resp == exp_fetch_resp)
        else report_mismatch("fetch_r_resp", dw'($sampled(fetch_r_resp)), dw'(exp_fetch_resp));
    assert property (@(posedge clk) disable iff (!rst_n)
        data_b_valid && data_b_ready |-> data_b_resp == exp_b_resp)
        else report_mismatch("data_b_resp", dw'($sampled(data_b_resp)), dw'(exp_b_resp));

    // address and data of a write share one ready
    assert property (@(posedge clk) disable iff (!rst_n)
        data_w_ready == data_aw_ready)
        else report_mismatch("data_w_ready", dw'($sampled(data_w_ready)),
                             dw'($sampled(data_aw_ready)));

    // responses held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        data_r_valid && !data_r_ready |=> data_r_valid && $stable(data_r_data))
        else report_failure("data read response changed while data_r_ready was low");
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid && !fetch_r_ready |=> fetch_r_valid && $stable(fetch_r_data))
        else report_failure("fetch read response changed while fetch_r_ready was low");

    always @(posedge clk) begin
        if (rst_n) begin
            checks += int'(data_r_valid && data_r_ready) + int'(fetch_r_valid && fetch_r_ready)
                    + int'(data_b_valid && data_b_ready);
        end
    end

    initial begin
        #((n_transfers * 20 + 5) * clk_period);
        $display("timeout: the planned transfers did not complete in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        fetch_ar_valid = 1'b0;
        fetch_ar_addr  = '0;
        fetch_r_ready  = 1'b1;
        data_ar_valid  = 1'b0;
        data_ar_addr   = '0;
        data_r_ready   = 1'b1;
        data_aw_valid  = 1'b0;
        data_aw_addr   = '0;
        data_w_valid   = 1'b0;
        data_w_data    = '0;
        data_w_strb    = '0;
        data_b_ready   = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        write_word(dtcm_base + 32'h40, $random(seed), 4'hf);
        read_data(dtcm_base + 32'h40, 0);
        finish_test("dtcm write and read back");

        // bytes 0 and 2 only
        write_word(dtcm_base + 32'h40, $random(seed), 4'b0101);
        read_data(dtcm_base + 32'h40, 0);
        finish_test("dtcm partial strobe merge");

        write_word(itcm_base + 32'h100, $random(seed), 4'hf);
        read_fetch(itcm_base + 32'h100, 0);
        finish_test("itcm data write, fetch read");

        write_word(itcm_base + 32'h200, $random(seed), 4'hf);
        write_word(itcm_base + 32'h204, $random(seed), 4'hf);
        fork
            read_fetch(itcm_base + 32'h200, 0);
            read_data(itcm_base + 32'h204, 0);
        join
        finish_test("fetch and data read itcm together");

        read_data(32'h0002_0000, 0);
        write_word(32'h0002_0000, $random(seed), 4'hf);
        read_fetch(dtcm_base + 32'h40, 0);
        finish_test("decode errors");

        read_data(dtcm_base + 32'h40, 4);
        read_fetch(itcm_base + 32'h100, 4);
        finish_test("read back-pressure");

        $display("%0d tests, %0d failed, %0d responses checked, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
tcm_pkg.sv
tcm_bank.sv
itcm_read_arbiter.sv
data_port_router.sv
tcm_subsystem.sv
tb_tcm_subsystem.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_tcm_subsystem
FILELIST  := files.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
